/* src/lsu_sched_pkg.sv */
/*
 * Shared definitions for the load/store issue scheduler.
 * Holds the field widths, the entry state and hazard encodings, the
 * dispatched payload layout and the commit id age compare.
 * Import it with a wildcard in the module header where needed.
 */
package lsu_sched_pkg;

  // ------------------------------------------------------------
  // Field widths
  // ------------------------------------------------------------
  localparam int CMT_ID_W = 6;   // Commit id, wraps modulo 2^6
  localparam int RNID_W   = 6;   // Physical register id
  localparam int ADDR_W   = 16;  // Address offset payload

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    ST_FREE     = 2'd0,
    ST_WAIT     = 2'd1,  // Waiting for operand or for pick
    ST_ISSUED   = 2'd2,  // Sent down, waiting for EX1 report
    ST_HAZ_WAIT = 2'd3   // Parked on a hazard
  } lsu_sched_state_t;

  // Hazard reported by the first execute stage
  typedef enum logic [1:0] {
    HAZ_NONE      = 2'd0,
    HAZ_TLB_MISS  = 2'd1,
    HAZ_UC_ACCESS = 2'd2
  } lsu_haz_t;

  // Dispatched memory operation
  typedef struct packed {
    logic [CMT_ID_W-1:0] cmt_id;
    logic                is_store;
    logic                rs1_valid;  // Base register is used
    logic [RNID_W-1:0]   rs1_rnid;
    logic                rs1_ready;  // Base register value available
    logic [ADDR_W-1:0]   addr_off;
  } lsu_payload_t;

  // ------------------------------------------------------------
  // Age compare
  // ------------------------------------------------------------
  // True when id a sits at or after id b in program order. Both are
  // measured as distance from the ROB head so the wrap is harmless.
  function automatic logic is_younger_or_same(
    input logic [CMT_ID_W-1:0] a,
    input logic [CMT_ID_W-1:0] b,
    input logic [CMT_ID_W-1:0] head
  );
    logic [CMT_ID_W-1:0] a_dist;
    logic [CMT_ID_W-1:0] b_dist;
    a_dist = a - head;
    b_dist = b - head;
    return a_dist >= b_dist;
  endfunction

endpackage

/* src/lsu_entry_if.sv */
/*
 * Per-entry link between allocator, scheduler entry and picker.
 * One instance per entry; the allocator writes a new operation in,
 * the entry reports its status, the picker grants issue.
 */
`timescale 1ns/1ps

interface lsu_entry_if
  import lsu_sched_pkg::*;
();

  logic         put;          // Load this entry this cycle
  lsu_payload_t put_payload;
  logic         busy;         // Entry not FREE
  logic         ready;        // Eligible for issue
  lsu_payload_t payload;      // Stored operation
  logic         picked;       // Granted by the picker

  modport alloc (
    output put,
    output put_payload,
    input  busy
  );

  modport entry (
    input  put,
    input  put_payload,
    input  picked,
    output busy,
    output ready,
    output payload
  );

  modport pick (
    input  busy,
    input  ready,
    input  payload,
    output picked
  );

endinterface

/* src/lsu_sched_alloc.sv */
/*
 * Dispatch allocator for the scheduler.
 * Steers each accepted put to the lowest-index free entry and keeps
 * o_put_ready registered. Ready is predicted from this cycle's free
 * mask less the entry taken now, so it never claims a free slot that
 * is not there; a slot freed by an entry shows up one cycle later.
 */
`timescale 1ns/1ps

module lsu_sched_alloc
  import lsu_sched_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  logic         i_put,
  input  lsu_payload_t i_put_payload,
  output logic         o_put_ready,
  lsu_entry_if.alloc   ent [NUM_ENTRIES]
);

  logic [NUM_ENTRIES-1:0] w_busy;
  logic [NUM_ENTRIES-1:0] w_free;
  logic [NUM_ENTRIES-1:0] w_sel_oh;     // Lowest free entry
  logic                   w_accept;
  logic                   r_put_ready;

  assign w_free   = ~w_busy;
  assign w_sel_oh = w_free & ~(w_free - 1'b1);  // Isolate lowest set bit
  assign w_accept = i_put & r_put_ready;

  // ------------------------------------------------------------
  // Per-entry steering
  // ------------------------------------------------------------
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_steer
    assign w_busy[i]          = ent[i].busy;
    assign ent[i].put         = w_accept & w_sel_oh[i];
    assign ent[i].put_payload = i_put_payload;  // Broadcast, put selects
  end

  // ------------------------------------------------------------
  // Ready flag
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_put_ready <= 1'b1;  // All entries free out of reset
    end else if (w_accept) begin
      r_put_ready <= |(w_free & ~w_sel_oh);  // Taken slot stays busy
    end else begin
      r_put_ready <= |w_free;
    end
  end

  assign o_put_ready = r_put_ready;

endmodule

/* src/lsu_sched_entry.sv */
/*
 * One load/store scheduler entry.
 * Holds a dispatched operation, snoops the writeback bus for its base
 * register, requests issue when ready, and follows the EX1 report:
 * a clean report frees it, a hazard parks it until the TLB resolves
 * or, for an uncached access, until it heads the ROB with the store
 * buffer drained. A flush at or older than its id frees it.
 */
`timescale 1ns/1ps

module lsu_sched_entry
  import lsu_sched_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  lsu_entry_if.entry                     ent,
  input  logic [$clog2(NUM_ENTRIES)-1:0] i_my_index,

  // Writeback wakeup
  input  logic                           i_wb_valid,
  input  logic [RNID_W-1:0]              i_wb_rnid,

  // EX1 report
  input  logic                           i_ex1_valid,
  input  logic [$clog2(NUM_ENTRIES)-1:0] i_ex1_index,
  input  lsu_haz_t                       i_ex1_haz,

  // Hazard release
  input  logic                           i_tlb_resolve,
  input  logic [CMT_ID_W-1:0]            i_rob_head_cmt_id,
  input  logic                           i_st_buffer_empty,

  // Flush
  input  logic                           i_flush,
  input  logic [CMT_ID_W-1:0]            i_flush_cmt_id
);

  lsu_sched_state_t r_state;
  lsu_sched_state_t w_state_next;
  lsu_haz_t         r_haz;
  lsu_haz_t         w_haz_next;
  lsu_payload_t     r_payload;
  lsu_payload_t     w_put_payload;

  logic w_busy;
  logic w_ready;
  logic w_wakeup;
  logic w_put_wakeup;
  logic w_flush;
  logic w_put_flush;
  logic w_ex1_hit;
  logic w_uc_release;

  // ------------------------------------------------------------
  // Status decode
  // ------------------------------------------------------------
  assign w_busy = (r_state != ST_FREE);

  assign w_wakeup = i_wb_valid & r_payload.rs1_valid &
                    (i_wb_rnid == r_payload.rs1_rnid);
  // Wakeup landing in the dispatch cycle
  assign w_put_wakeup = i_wb_valid & ent.put_payload.rs1_valid &
                        (i_wb_rnid == ent.put_payload.rs1_rnid);

  assign w_flush = i_flush & w_busy &
                   is_younger_or_same(r_payload.cmt_id, i_flush_cmt_id,
                                      i_rob_head_cmt_id);
  assign w_put_flush = i_flush &
                       is_younger_or_same(ent.put_payload.cmt_id, i_flush_cmt_id,
                                          i_rob_head_cmt_id);

  assign w_ex1_hit    = i_ex1_valid & (i_ex1_index == i_my_index);
  assign w_uc_release = (i_rob_head_cmt_id == r_payload.cmt_id) & i_st_buffer_empty;

  // Killed entries must not be granted in the flush cycle
  assign w_ready = (r_state == ST_WAIT) & !w_flush &
                   (!r_payload.rs1_valid | r_payload.rs1_ready);

  // ------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    w_haz_next   = r_haz;
    case (r_state)
      ST_FREE: begin
        if (ent.put && !w_put_flush) begin  // Doomed dispatch stays FREE
          w_state_next = ST_WAIT;
          w_haz_next   = HAZ_NONE;
        end
      end
      ST_WAIT: begin
        if (w_flush) begin
          w_state_next = ST_FREE;
        end else if (ent.picked && w_ready) begin
          w_state_next = ST_ISSUED;
        end
      end
      ST_ISSUED: begin
        if (w_flush) begin
          w_state_next = ST_FREE;
        end else if (w_ex1_hit) begin
          if (i_ex1_haz == HAZ_NONE) begin
            w_state_next = ST_FREE;  // Clean, retire
          end else begin
            w_state_next = ST_HAZ_WAIT;
            w_haz_next   = i_ex1_haz;
          end
        end
      end
      ST_HAZ_WAIT: begin
        if (w_flush) begin
          w_state_next = ST_FREE;
        end else begin
          case (r_haz)
            HAZ_TLB_MISS:  if (i_tlb_resolve) w_state_next = ST_WAIT;
            HAZ_UC_ACCESS: if (w_uc_release)  w_state_next = ST_WAIT;
            default:       w_state_next = ST_WAIT;  // Nothing to wait on
          endcase
        end
      end
      default: w_state_next = ST_FREE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_FREE;
      r_haz   <= HAZ_NONE;
    end else begin
      r_state <= w_state_next;
      r_haz   <= w_haz_next;
    end
  end

  // ------------------------------------------------------------
  // Payload and operand tracking
  // ------------------------------------------------------------
  always_comb begin
    w_put_payload           = ent.put_payload;
    w_put_payload.rs1_ready = ent.put_payload.rs1_ready | w_put_wakeup;
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == ST_FREE) && ent.put) begin
      r_payload <= w_put_payload;
    end else if (w_busy && w_wakeup) begin
      r_payload.rs1_ready <= 1'b1;  // Seen on writeback
    end
  end

  assign ent.busy    = w_busy;
  assign ent.ready   = w_ready;
  assign ent.payload = r_payload;

endmodule

/* src/lsu_sched_pick.sv */
/*
 * Oldest-ready issue picker.
 * An age matrix records, for each entry, which entries were already
 * busy when it was allocated. Among the ready entries the one with no
 * older ready entry is granted; its id and address are registered as
 * the issue output for the next cycle.
 */
`timescale 1ns/1ps

module lsu_sched_pick
  import lsu_sched_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  lsu_entry_if.pick                      ent [NUM_ENTRIES],
  output logic                           o_issue_valid,
  output logic [$clog2(NUM_ENTRIES)-1:0] o_issue_index,
  output logic [CMT_ID_W-1:0]            o_issue_cmt_id,
  output logic [ADDR_W-1:0]              o_issue_addr
);

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  logic [NUM_ENTRIES-1:0] w_busy;
  logic [NUM_ENTRIES-1:0] w_ready;
  logic [NUM_ENTRIES-1:0] w_new;       // Became busy this cycle
  logic [NUM_ENTRIES-1:0] w_grant;
  logic [NUM_ENTRIES-1:0] r_busy_q;
  logic [NUM_ENTRIES-1:0] r_older [NUM_ENTRIES];  // [i][j] j older than i
  logic [NUM_ENTRIES-1:0] w_older [NUM_ENTRIES];
  lsu_payload_t           w_payload [NUM_ENTRIES];
  logic [IDX_W-1:0]       w_sel_index;
  logic [CMT_ID_W-1:0]    w_sel_cmt_id;
  logic [ADDR_W-1:0]      w_sel_addr;

  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_ent
    assign w_busy[i]     = ent[i].busy;
    assign w_ready[i]    = ent[i].ready;
    assign w_payload[i]  = ent[i].payload;
    assign ent[i].picked = w_grant[i];
  end

  assign w_new = w_busy & ~r_busy_q;

  // ------------------------------------------------------------
  // Age matrix, current view includes this cycle's allocation
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (w_new[i]) begin
        w_older[i] = r_busy_q;  // Everything already held is older
      end else begin
        w_older[i] = r_older[i] & ~w_new;
      end
      w_grant[i] = w_ready[i] & ~|(w_ready & w_older[i]);
    end
  end

  always_comb begin
    w_sel_index  = '0;
    w_sel_cmt_id = '0;
    w_sel_addr   = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (w_grant[i]) begin  // At most one grant
        w_sel_index  = IDX_W'(i);
        w_sel_cmt_id = w_payload[i].cmt_id;
        w_sel_addr   = w_payload[i].addr_off;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy_q      <= '0;
      o_issue_valid <= 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        r_older[i] <= '0;
      end
    end else begin
      r_busy_q      <= w_busy;
      o_issue_valid <= |w_grant;
      r_older       <= w_older;
    end
  end

  // Issue payload, qualified by o_issue_valid
  always_ff @(posedge i_clk) begin
    o_issue_index  <= w_sel_index;
    o_issue_cmt_id <= w_sel_cmt_id;
    o_issue_addr   <= w_sel_addr;
  end

endmodule

/* src/lsu_sched_top.sv */
/*
 * Load/store issue scheduler top level.
 * Packs the dispatch ports into a payload, then ties the allocator,
 * NUM_ENTRIES scheduler entries and the oldest-ready picker together.
 * Pipeline, TLB, ROB and store buffer status arrive as plain ports.
 */
`timescale 1ns/1ps

module lsu_sched_top
  import lsu_sched_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  // Dispatch
  input  logic                           i_put,
  input  logic [CMT_ID_W-1:0]            i_put_cmt_id,
  input  logic                           i_put_is_store,
  input  logic                           i_put_rs1_valid,
  input  logic [RNID_W-1:0]              i_put_rs1_rnid,
  input  logic                           i_put_rs1_ready,
  input  logic [ADDR_W-1:0]              i_put_addr,
  output logic                           o_put_ready,

  // Broadcast status
  input  logic                           i_wb_valid,
  input  logic [RNID_W-1:0]              i_wb_rnid,
  input  logic                           i_ex1_valid,
  input  logic [$clog2(NUM_ENTRIES)-1:0] i_ex1_index,
  input  lsu_haz_t                       i_ex1_haz,
  input  logic                           i_tlb_resolve,
  input  logic [CMT_ID_W-1:0]            i_rob_head_cmt_id,
  input  logic                           i_st_buffer_empty,
  input  logic                           i_flush,
  input  logic [CMT_ID_W-1:0]            i_flush_cmt_id,

  // Issue
  output logic                           o_issue_valid,
  output logic [$clog2(NUM_ENTRIES)-1:0] o_issue_index,
  output logic [CMT_ID_W-1:0]            o_issue_cmt_id,
  output logic [ADDR_W-1:0]              o_issue_addr
);

  lsu_payload_t w_put_payload;

  lsu_entry_if ent_if [NUM_ENTRIES] ();

  assign w_put_payload = '{cmt_id:    i_put_cmt_id,
                           is_store:  i_put_is_store,
                           rs1_valid: i_put_rs1_valid,
                           rs1_rnid:  i_put_rs1_rnid,
                           rs1_ready: i_put_rs1_ready,
                           addr_off:  i_put_addr};

  lsu_sched_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) u_alloc (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_put(i_put), .i_put_payload(w_put_payload),
    .o_put_ready(o_put_ready), .ent(ent_if)
  );

  // ------------------------------------------------------------
  // Entries
  // ------------------------------------------------------------
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
    lsu_sched_entry #(.NUM_ENTRIES(NUM_ENTRIES)) u_entry (
      .i_clk(i_clk), .i_reset_n(i_reset_n), .ent(ent_if[i]),
      .i_my_index($clog2(NUM_ENTRIES)'(i)),
      .i_wb_valid(i_wb_valid), .i_wb_rnid(i_wb_rnid),
      .i_ex1_valid(i_ex1_valid), .i_ex1_index(i_ex1_index), .i_ex1_haz(i_ex1_haz),
      .i_tlb_resolve(i_tlb_resolve), .i_rob_head_cmt_id(i_rob_head_cmt_id),
      .i_st_buffer_empty(i_st_buffer_empty),
      .i_flush(i_flush), .i_flush_cmt_id(i_flush_cmt_id)
    );
  end

  lsu_sched_pick #(.NUM_ENTRIES(NUM_ENTRIES)) u_pick (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .ent(ent_if),
    .o_issue_valid(o_issue_valid), .o_issue_index(o_issue_index),
    .o_issue_cmt_id(o_issue_cmt_id), .o_issue_addr(o_issue_addr)
  );

endmodule

/* sim/tb_clkgen.sv */
/*
 * Testbench clock and reset source.
 * Free-running clock of PERIOD_NS, reset held low for RESET_CYCLES
 * rising edges and released a quarter period after the last one.
 */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #(PERIOD_NS / 4);  // Away from both clock edges
    o_reset_n = 1'b1;
  end

endmodule

/* sim/tb_lsu_sched.sv */
/*
 * Testbench for the load/store issue scheduler.
 * Directed tests drive dispatch, wakeup, EX1 reports, hazard release
 * and flush on the falling edge. A cycle model keeps the entries in
 * allocation order and predicts every issue and o_put_ready, and a
 * comparing process checks the DUT against it on each falling edge.
 */
`timescale 1ns/1ps

module tb_lsu_sched
  import lsu_sched_pkg::*;
();

  localparam int N               = 8;
  localparam int IW              = $clog2(N);
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 200;
  localparam int ISSUE_WAIT      = 40;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_put;
  logic [CMT_ID_W-1:0] i_put_cmt_id;
  logic                i_put_is_store;
  logic                i_put_rs1_valid;
  logic [RNID_W-1:0]   i_put_rs1_rnid;
  logic                i_put_rs1_ready;
  logic [ADDR_W-1:0]   i_put_addr;
  logic                o_put_ready;
  logic                i_wb_valid;
  logic [RNID_W-1:0]   i_wb_rnid;
  logic                i_ex1_valid;
  logic [IW-1:0]       i_ex1_index;
  lsu_haz_t            i_ex1_haz;
  logic                i_tlb_resolve;
  logic [CMT_ID_W-1:0] i_rob_head_cmt_id;
  logic                i_st_buffer_empty;
  logic                i_flush;
  logic [CMT_ID_W-1:0] i_flush_cmt_id;
  logic                o_issue_valid;
  logic [IW-1:0]       o_issue_index;
  logic [CMT_ID_W-1:0] o_issue_cmt_id;
  logic [ADDR_W-1:0]   o_issue_addr;

  tb_clkgen #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clkgen (
    .o_clk(i_clk), .o_reset_n(i_reset_n)
  );

  lsu_sched_top #(.NUM_ENTRIES(N)) dut0 (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_put(i_put), .i_put_cmt_id(i_put_cmt_id), .i_put_is_store(i_put_is_store),
    .i_put_rs1_valid(i_put_rs1_valid), .i_put_rs1_rnid(i_put_rs1_rnid),
    .i_put_rs1_ready(i_put_rs1_ready), .i_put_addr(i_put_addr),
    .o_put_ready(o_put_ready),
    .i_wb_valid(i_wb_valid), .i_wb_rnid(i_wb_rnid),
    .i_ex1_valid(i_ex1_valid), .i_ex1_index(i_ex1_index), .i_ex1_haz(i_ex1_haz),
    .i_tlb_resolve(i_tlb_resolve), .i_rob_head_cmt_id(i_rob_head_cmt_id),
    .i_st_buffer_empty(i_st_buffer_empty),
    .i_flush(i_flush), .i_flush_cmt_id(i_flush_cmt_id),
    .o_issue_valid(o_issue_valid), .o_issue_index(o_issue_index),
    .o_issue_cmt_id(o_issue_cmt_id), .o_issue_addr(o_issue_addr)
  );

  string       test_name = "reset";
  int          n_checks;
  int          n_mismatch;
  int          n_other;
  logic [31:0] lfsr_state = 32'h2bfb_5cf4;

  // Issues seen on the DUT output, per commit id
  int            issue_cnt [1 << CMT_ID_W];
  logic [IW-1:0] issue_idx [1 << CMT_ID_W];
  int            issue_order [$];

  // ------------------------------------------------------------
  // Reference model state
  // ------------------------------------------------------------
  lsu_sched_state_t    m_state [N];
  lsu_haz_t            m_haz [N];
  logic [CMT_ID_W-1:0] m_cmt [N];
  logic [ADDR_W-1:0]   m_addr [N];
  logic                m_rs1_valid [N];
  logic [RNID_W-1:0]   m_rnid [N];
  logic                m_rs1_ready [N];
  int                  m_age_q [$];  // Slot numbers, oldest first
  logic                m_put_ready;
  logic                exp_valid;
  logic [IW-1:0]       exp_index;
  logic [CMT_ID_W-1:0] exp_cmt;
  logic [ADDR_W-1:0]   exp_addr;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32,22,2,1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Program order as distance from the ROB head, counted modulo 2^CMT_ID_W
  function automatic logic at_or_after(input logic [CMT_ID_W-1:0] a,
                                       input logic [CMT_ID_W-1:0] b,
                                       input logic [CMT_ID_W-1:0] head);
    int span;
    int dist_a;
    int dist_b;
    span   = 1 << CMT_ID_W;
    dist_a = (int'(a) - int'(head) + span) % span;
    dist_b = (int'(b) - int'(head) + span) % span;
    return dist_a >= dist_b;
  endfunction

  // Expected grant, first ready slot in allocation order, -1 if none
  function automatic int oldest_ready(input logic [N-1:0] rdy);
    foreach (m_age_q[k]) begin
      if (rdy[m_age_q[k]]) return m_age_q[k];
    end
    return -1;
  endfunction

  always @(posedge i_clk or negedge i_reset_n) begin : ref_model
    logic [N-1:0] busy;
    logic [N-1:0] rdy;
    logic [N-1:0] kill;
    logic         accept;
    logic         any_left;
    int           g;
    int           sel;
    int           keep_q [$];
    if (!i_reset_n) begin
      for (int i = 0; i < N; i++) begin
        m_state[i]     = ST_FREE;
        m_haz[i]       = HAZ_NONE;
        m_rs1_valid[i] = 1'b0;
        m_rs1_ready[i] = 1'b0;
      end
      m_age_q.delete();
      m_put_ready = 1'b1;
      exp_valid   = 1'b0;
    end else begin
      for (int i = 0; i < N; i++) begin
        busy[i] = (m_state[i] != ST_FREE);
        kill[i] = i_flush && busy[i] &&
                  at_or_after(m_cmt[i], i_flush_cmt_id, i_rob_head_cmt_id);
        rdy[i]  = (m_state[i] == ST_WAIT) && !kill[i] &&
                  (!m_rs1_valid[i] || m_rs1_ready[i]);
      end
      g         = oldest_ready(rdy);
      exp_valid = (g >= 0);
      if (g >= 0) begin
        exp_index = IW'(g);
        exp_cmt   = m_cmt[g];
        exp_addr  = m_addr[g];
      end

      // Allocation and the registered ready flag
      accept = i_put && m_put_ready;
      sel    = -1;
      for (int i = N - 1; i >= 0; i--) begin
        if (!busy[i]) sel = i;  // Lowest free slot
      end
      any_left = 1'b0;
      for (int i = 0; i < N; i++) begin
        if (!busy[i] && !(accept && i == sel)) any_left = 1'b1;
      end
      m_put_ready = any_left;

      for (int i = 0; i < N; i++) begin
        if (busy[i] && i_wb_valid && m_rs1_valid[i] && i_wb_rnid == m_rnid[i]) begin
          m_rs1_ready[i] = 1'b1;
        end
        if (kill[i]) begin
          m_state[i] = ST_FREE;
        end else if (m_state[i] == ST_WAIT && i == g) begin
          m_state[i] = ST_ISSUED;
        end else if (m_state[i] == ST_ISSUED && i_ex1_valid && i_ex1_index == IW'(i)) begin
          m_state[i] = (i_ex1_haz == HAZ_NONE) ? ST_FREE : ST_HAZ_WAIT;
          m_haz[i]   = i_ex1_haz;
        end else if (m_state[i] == ST_HAZ_WAIT) begin
          if ((m_haz[i] == HAZ_TLB_MISS && i_tlb_resolve) ||
              (m_haz[i] == HAZ_UC_ACCESS && i_rob_head_cmt_id == m_cmt[i] &&
               i_st_buffer_empty)) begin
            m_state[i] = ST_WAIT;
          end
        end
      end

      if (accept && sel >= 0 &&
          !(i_flush && at_or_after(i_put_cmt_id, i_flush_cmt_id, i_rob_head_cmt_id))) begin
        m_state[sel]     = ST_WAIT;
        m_haz[sel]       = HAZ_NONE;
        m_cmt[sel]       = i_put_cmt_id;
        m_addr[sel]      = i_put_addr;
        m_rs1_valid[sel] = i_put_rs1_valid;
        m_rnid[sel]      = i_put_rs1_rnid;
        m_rs1_ready[sel] = i_put_rs1_ready ||
                           (i_wb_valid && i_put_rs1_valid && i_wb_rnid == i_put_rs1_rnid);
        m_age_q.push_back(sel);
      end
      keep_q = {};
      foreach (m_age_q[k]) begin
        if (m_state[m_age_q[k]] != ST_FREE) keep_q.push_back(m_age_q[k]);
      end
      m_age_q = keep_q;
    end
  end

  // ------------------------------------------------------------
  // Issue log and comparison
  // ------------------------------------------------------------
  always @(posedge i_clk) begin : issue_monitor
    if (i_reset_n && o_issue_valid) begin
      issue_cnt[o_issue_cmt_id]++;
      issue_idx[o_issue_cmt_id] = o_issue_index;
      issue_order.push_back(int'(o_issue_cmt_id));
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    n_mismatch++;
    $display("error %s: %s expected %0h actual %0h at %0t",
             test_name, what, exp_v, act_v, $time);
  endtask

  task automatic report_failure(input string msg);
    n_other++;
    $display("%s failed at %0t: %s", test_name, $time, msg);
  endtask

  always @(negedge i_clk) begin : compare
    if (i_reset_n) begin
      n_checks++;
      if (o_issue_valid !== exp_valid) begin
        report_mismatch("o_issue_valid", 32'(exp_valid), 32'(o_issue_valid));
      end else if (exp_valid) begin
        if (o_issue_index !== exp_index) begin
          report_mismatch("o_issue_index", 32'(exp_index), 32'(o_issue_index));
        end
        if (o_issue_cmt_id !== exp_cmt) begin
          report_mismatch("o_issue_cmt_id", 32'(exp_cmt), 32'(o_issue_cmt_id));
        end
        if (o_issue_addr !== exp_addr) begin
          report_mismatch("o_issue_addr", 32'(exp_addr), 32'(o_issue_addr));
        end
      end
      if (o_put_ready !== m_put_ready) begin
        report_mismatch("o_put_ready", 32'(m_put_ready), 32'(o_put_ready));
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic next_cycle();
    @(negedge i_clk);
    i_put         = 1'b0;  // Pulses last one cycle
    i_wb_valid    = 1'b0;
    i_ex1_valid   = 1'b0;
    i_tlb_resolve = 1'b0;
    i_flush       = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic drive_put(input int cmt, input logic rs1_valid, input logic [RNID_W-1:0] rnid,
                           input logic rs1_ready);
    i_put           = 1'b1;
    i_put_cmt_id    = CMT_ID_W'(cmt);
    i_put_is_store  = i_put_cmt_id[0];  // Alternate loads and stores
    i_put_rs1_valid = rs1_valid;
    i_put_rs1_rnid  = rnid;
    i_put_rs1_ready = rs1_ready;
    i_put_addr      = ADDR_W'(rand_bits(ADDR_W));
  endtask

  task automatic drive_wb(input logic [RNID_W-1:0] rnid);
    i_wb_valid = 1'b1;
    i_wb_rnid  = rnid;
  endtask

  // Waits for the n-th issue of cmt, then sends its EX1 report
  task automatic report_after_issue(input int cmt, input int n, input lsu_haz_t haz);
    int waited;
    waited = 0;
    while (issue_cnt[cmt] < n && waited < ISSUE_WAIT) begin
      next_cycle();
      waited++;
    end
    if (issue_cnt[cmt] < n) begin
      report_failure($sformatf("cmt %0d not issued %0d time(s) within %0d cycles",
                               cmt, n, ISSUE_WAIT));
    end else begin
      i_ex1_valid = 1'b1;
      i_ex1_index = issue_idx[cmt];
      i_ex1_haz   = haz;
      next_cycle();
    end
  endtask

  task automatic expect_issues(input int cmt, input int n);
    if (issue_cnt[cmt] != n) begin
      report_mismatch($sformatf("issue count of cmt %0d", cmt), 32'(n), 32'(issue_cnt[cmt]));
    end
  endtask

  task automatic clear_log(input string name);
    test_name = name;
    foreach (issue_cnt[c]) issue_cnt[c] = 0;
    issue_order.delete();
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  initial begin : main
    logic [RNID_W-1:0] base;
    logic              start_rdy [4];
    i_put = 1'b0;
    i_put_cmt_id = '0;
    i_put_is_store = 1'b0;
    i_put_rs1_valid = 1'b0;
    i_put_rs1_rnid = '0;
    i_put_rs1_ready = 1'b0;
    i_put_addr = '0;
    i_wb_valid = 1'b0;
    i_wb_rnid = '0;
    i_ex1_valid = 1'b0;
    i_ex1_index = '0;
    i_ex1_haz = HAZ_NONE;
    i_tlb_resolve = 1'b0;
    i_rob_head_cmt_id = '0;
    i_st_buffer_empty = 1'b1;
    i_flush = 1'b0;
    i_flush_cmt_id = '0;
    @(posedge i_reset_n);
    next_cycle();

    clear_log("oldest_first");
    for (int k = 0; k < 4; k++) begin
      drive_put(1 + k, 1'b0, '0, 1'b0);
      next_cycle();
    end
    for (int k = 0; k < 4; k++) report_after_issue(1 + k, 1, HAZ_NONE);
    if (issue_order.size() != 4) begin
      report_failure($sformatf("saw %0d issues instead of 4", issue_order.size()));
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (issue_order[k] != 1 + k) begin
          report_mismatch("issue order", 32'(1 + k), 32'(issue_order[k]));
        end
      end
    end

    clear_log("wakeup");
    base = RNID_W'(rand_bits(RNID_W));
    for (int k = 0; k < 4; k++) begin
      start_rdy[k] = rand_bits(1) != 0;
      drive_put(10 + k, 1'b1, base + RNID_W'(k % 2), start_rdy[k]);  // Pairs share an rnid
      next_cycle();
    end
    drive_put(14, 1'b1, base + 2'd2, 1'b0);
    drive_wb(base + 2'd2);  // Wakeup in the dispatch cycle
    next_cycle();
    idle(3);
    for (int k = 0; k < 4; k++) begin
      if (!start_rdy[k] && issue_cnt[10 + k] != 0) begin
        report_failure($sformatf("cmt %0d issued before its wakeup", 10 + k));
      end
    end
    drive_wb(base + 1'b1);
    next_cycle();
    idle(2);
    drive_wb(base);
    next_cycle();
    idle(2);
    for (int k = 0; k < 5; k++) report_after_issue(10 + k, 1, HAZ_NONE);

    clear_log("tlb_miss");
    drive_put(20, 1'b0, '0, 1'b0);
    next_cycle();
    report_after_issue(20, 1, HAZ_TLB_MISS);
    idle(5);
    expect_issues(20, 1);
    i_tlb_resolve = 1'b1;
    next_cycle();
    report_after_issue(20, 2, HAZ_NONE);
    idle(3);
    expect_issues(20, 2);

    clear_log("uncached");
    drive_put(30, 1'b0, '0, 1'b0);
    next_cycle();
    report_after_issue(30, 1, HAZ_UC_ACCESS);
    i_rob_head_cmt_id = 6'd30;  // Oldest, store buffer busy
    i_st_buffer_empty = 1'b0;
    idle(4);
    expect_issues(30, 1);
    i_rob_head_cmt_id = 6'd29;  // Store buffer empty, not oldest
    i_st_buffer_empty = 1'b1;
    idle(4);
    expect_issues(30, 1);
    i_rob_head_cmt_id = 6'd30;
    next_cycle();
    report_after_issue(30, 2, HAZ_NONE);
    i_rob_head_cmt_id = '0;
    idle(2);
    expect_issues(30, 2);

    clear_log("flush");
    base = RNID_W'(rand_bits(RNID_W));
    for (int k = 0; k < 4; k++) begin
      drive_put(40 + k, 1'b1, base, 1'b0);
      next_cycle();
    end
    i_flush        = 1'b1;
    i_flush_cmt_id = 6'd42;
    drive_put(44, 1'b0, '0, 1'b0);  // Younger than the flush id
    next_cycle();
    drive_wb(base);
    next_cycle();
    idle(4);
    for (int c = 42; c <= 44; c++) expect_issues(c, 0);
    report_after_issue(40, 1, HAZ_NONE);
    report_after_issue(41, 1, HAZ_NONE);

    clear_log("back_pressure");
    for (int k = 0; k < N; k++) begin
      drive_put(50 + k, 1'b0, '0, 1'b0);
      next_cycle();
    end
    if (o_put_ready !== 1'b0) report_mismatch("o_put_ready when full", 32'd0, 32'(o_put_ready));
    drive_put(50 + N, 1'b0, '0, 1'b0);  // Lost while full
    next_cycle();
    idle(2);
    report_after_issue(50, 1, HAZ_NONE);
    next_cycle();
    if (o_put_ready !== 1'b1) report_mismatch("o_put_ready after free", 32'd1, 32'(o_put_ready));
    for (int k = 1; k < N; k++) report_after_issue(50 + k, 1, HAZ_NONE);
    idle(3);
    expect_issues(50 + N, 0);
    @(posedge i_clk);  // Let the last falling-edge compare settle

    $display("Run finished: %0d checks, %0d value mismatches, %0d other failures",
             n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
src/lsu_sched_pkg.sv
src/lsu_entry_if.sv
src/lsu_sched_alloc.sv
src/lsu_sched_entry.sv
src/lsu_sched_pick.sv
src/lsu_sched_top.sv
sim/tb_clkgen.sv
sim/tb_lsu_sched.sv

/* run.sh */
#!/bin/sh
# Build the scheduler testbench with Verilator, run it, and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f project.f \
  --top-module tb_lsu_sched --Mdir obj_dir -o tb_lsu_sched
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_lsu_sched > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
